// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// Datapath and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 2 ** REG_ADDR_W;

	// Machine word and register index
	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Sequential pc increment
	localparam word_t PC_STEP = 32'd4;

	// Major opcodes of the supported subset
	localparam logic [6:0] OPCODE_R_TYPE = 7'h33;
	localparam logic [6:0] OPCODE_I_TYPE = 7'h13;
	localparam logic [6:0] OPCODE_B_TYPE = 7'h63;
	localparam logic [6:0] OPCODE_J_TYPE = 7'h6F;

	// add, addi and beq all share funct3 zero
	localparam logic [2:0] FUNCT3_ADD = 3'b000;
	localparam logic [6:0] FUNCT7_ADD = 7'h00;
	localparam logic [6:0] FUNCT7_SUB = 7'h20;

	// ALU operation
	typedef enum logic {
		ALU_ADD,
		ALU_SUB
	} alu_op_e;

	// Immediate format
	typedef enum logic [1:0] {
		IMM_I,
		IMM_B,
		IMM_J
	} imm_sel_e;

endpackage

`default_nettype wire

// File: hdl/rv_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_ctrl_if;
	import rv_pkg::*;

	// Decoded control, all combinational from the current instruction
	alu_op_e   alu_op;
	logic      use_imm;
	imm_sel_e  imm_sel;
	logic      reg_write;
	logic      is_branch;
	logic      is_jump;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;

	// Decoder side
	modport dec_mp (
		output alu_op, use_imm, imm_sel, reg_write, is_branch, is_jump, rs1, rs2, rd
	);

	// Datapath side
	modport dp_mp (
		input alu_op, use_imm, imm_sel, reg_write, is_branch, is_jump, rs1, rs2, rd
	);

endinterface

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  rv_pkg::word_t   instr_i,
	rv_ctrl_if.dec_mp       ctrl_o
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// Fixed instruction fields
	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign ctrl_o.rd  = instr_i[11:7];
	assign ctrl_o.rs1 = instr_i[19:15];
	assign ctrl_o.rs2 = instr_i[24:20];

	always_comb begin
		// Unknown encodings fall through as a no-op
		ctrl_o.alu_op    = ALU_ADD;
		ctrl_o.use_imm   = 1'b0;
		ctrl_o.imm_sel   = IMM_I;
		ctrl_o.reg_write = 1'b0;
		ctrl_o.is_branch = 1'b0;
		ctrl_o.is_jump   = 1'b0;

		case (opcode)
			OPCODE_R_TYPE: begin
				// add or sub only
				if (funct3 == FUNCT3_ADD && (funct7 == FUNCT7_ADD || funct7 == FUNCT7_SUB)) begin
					ctrl_o.alu_op    = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
					ctrl_o.reg_write = 1'b1;
				end
			end
			OPCODE_I_TYPE: begin
				// addi
				if (funct3 == FUNCT3_ADD) begin
					ctrl_o.use_imm   = 1'b1;
					ctrl_o.reg_write = 1'b1;
				end
			end
			OPCODE_B_TYPE: begin
				// beq, compared in execute
				if (funct3 == FUNCT3_ADD) begin
					ctrl_o.imm_sel   = IMM_B;
					ctrl_o.is_branch = 1'b1;
				end
			end
			OPCODE_J_TYPE: begin
				// jal links pc plus 4 into rd
				ctrl_o.imm_sel   = IMM_J;
				ctrl_o.reg_write = 1'b1;
				ctrl_o.is_jump   = 1'b1;
			end
			default: begin
			end
		endcase

		// Instruction classes ALU, branch and jump are mutually exclusive
		if (!$isunknown(instr_i)) begin
			assert ($onehot0({ctrl_o.reg_write & ~ctrl_o.is_jump,
			                  ctrl_o.is_branch, ctrl_o.is_jump}))
				else $error("decoder raised more than one instruction class");
		end
	end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic            clk,
	input  logic            rst_n_i,
	rv_ctrl_if.dp_mp        ctrl_i,
	input  rv_pkg::word_t   wr_data_i,
	output rv_pkg::word_t   rs1_data_o,
	output rv_pkg::word_t   rs2_data_o,
	output logic            wr_en_o
);
	import rv_pkg::*;

	// x0 has no storage
	word_t regs [1:NUM_REGS-1];

	// Write enable, also the exported writeback strobe
	assign wr_en_o = ctrl_i.reg_write && rst_n_i && (ctrl_i.rd != '0);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_o) begin
			regs[ctrl_i.rd] <= wr_data_i;
		end
	end

	// Asynchronous read ports, x0 reads zero
	always_comb begin
		rs1_data_o = (ctrl_i.rs1 == '0) ? '0 : regs[ctrl_i.rs1];
		rs2_data_o = (ctrl_i.rs2 == '0) ? '0 : regs[ctrl_i.rs2];
	end

	// x0 stays zero on both ports
	assert property (@(posedge clk) disable iff (!rst_n_i)
		((ctrl_i.rs1 != '0) || (rs1_data_o == '0)) &&
		((ctrl_i.rs2 != '0) || (rs2_data_o == '0)));

	// A write is visible on the next read of the same register
	assert property (@(posedge clk) disable iff (!rst_n_i)
		wr_en_o |=> (ctrl_i.rs1 != $past(ctrl_i.rd)) || (rs1_data_o == $past(wr_data_i)));

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	rv_ctrl_if.dp_mp        ctrl_i,
	input  rv_pkg::word_t   instr_i,
	input  rv_pkg::word_t   pc_i,
	input  rv_pkg::word_t   rs1_data_i,
	input  rv_pkg::word_t   rs2_data_i,
	output rv_pkg::word_t   imm_o,
	output rv_pkg::word_t   alu_result_o,
	output rv_pkg::word_t   wb_data_o,
	output logic            br_taken_o
);
	import rv_pkg::*;

	word_t op_b;
	word_t link_addr;

	// Sign-extended immediate in the selected format
	always_comb begin
		case (ctrl_i.imm_sel)
			IMM_I: begin
				imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			IMM_B: begin
				// Bit 0 always zero
				imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
				         instr_i[30:25], instr_i[11:8], 1'b0};
			end
			IMM_J: begin
				imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
				         instr_i[20], instr_i[30:21], 1'b0};
			end
			default: begin
				imm_o = '0;
			end
		endcase
	end

	// Operand B is rs2 or the immediate
	assign op_b = ctrl_i.use_imm ? imm_o : rs2_data_i;

	// Adder and subtractor, result wraps to XLEN
	always_comb begin
		if (ctrl_i.alu_op == ALU_SUB) begin
			alu_result_o = rs1_data_i - op_b;
		end else begin
			alu_result_o = rs1_data_i + op_b;
		end
	end

	// beq only, equality of raw register operands
	assign br_taken_o = ctrl_i.is_branch && (rs1_data_i == rs2_data_i);

	// Return address for jal
	assign link_addr = pc_i + PC_STEP;

	// Writeback value
	assign wb_data_o = ctrl_i.is_jump ? link_addr : alu_result_o;

endmodule

`default_nettype wire

// File: hdl/rv_pc.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pc (
	input  logic            clk,
	input  logic            rst_n_i,
	rv_ctrl_if.dp_mp        ctrl_i,
	input  rv_pkg::word_t   imm_i,
	input  logic            br_taken_i,
	output rv_pkg::word_t   pc_o
);
	import rv_pkg::*;

	word_t pc_q;
	word_t pc_next;

	// jal and taken beq are pc-relative
	always_comb begin
		if (ctrl_i.is_jump || br_taken_i) begin
			pc_next = pc_q + imm_i;
		end else begin
			pc_next = pc_q + PC_STEP;
		end
	end

	// One step per retired instruction
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

	// Word alignment holds across every update
	assert property (@(posedge clk) disable iff (!rst_n_i) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hdl/rv_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_props (
	input  logic            clk,
	input  logic            rst_n_i,
	rv_ctrl_if.dp_mp        ctrl_i,
	input  rv_pkg::word_t   pc_i,
	input  rv_pkg::word_t   imm_i,
	input  rv_pkg::word_t   rs1_data_i,
	input  rv_pkg::word_t   rs2_data_i,
	input  rv_pkg::word_t   wb_data_i
);
	import rv_pkg::*;

	logic is_rtype;
	logic is_itype;

	// Instruction class from decoded control
	assign is_rtype = ctrl_i.reg_write && !ctrl_i.use_imm && !ctrl_i.is_jump;
	assign is_itype = ctrl_i.reg_write && ctrl_i.use_imm;

	default clocking cb @(posedge clk);
	endclocking

	default disable iff (!rst_n_i);

	// add writes the operand sum into rd at this edge
	assert property (is_rtype && ctrl_i.alu_op == ALU_ADD |->
		wb_data_i == rs1_data_i + rs2_data_i);

	// sub
	assert property (is_rtype && ctrl_i.alu_op == ALU_SUB |->
		wb_data_i == rs1_data_i - rs2_data_i);

	// addi with sign-extended immediate
	assert property (is_itype |-> wb_data_i == rs1_data_i + imm_i);

	// beq moves pc to the target or falls through
	assert property (ctrl_i.is_branch |=>
		pc_i == ($past(rs1_data_i == rs2_data_i) ? $past(pc_i + imm_i)
		                                         : $past(pc_i + PC_STEP)));

	// jal target
	assert property (ctrl_i.is_jump |=> pc_i == $past(pc_i + imm_i));

	// jal link value
	assert property (ctrl_i.is_jump |-> wb_data_i == pc_i + PC_STEP);

	// Anything else falls through
	assert property (!ctrl_i.is_jump && !ctrl_i.is_branch |=>
		pc_i == $past(pc_i + PC_STEP));

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
	input  logic                clk,
	input  logic                rst_n_i,
	input  rv_pkg::word_t       instr_i,
	output rv_pkg::word_t       pc_o,
	output rv_pkg::word_t       alu_result_o,
	output logic                rd_wr_en_o,
	output rv_pkg::reg_addr_t   rd_addr_o,
	output rv_pkg::word_t       rd_data_o
);
	import rv_pkg::*;

	word_t rs1_data;
	word_t rs2_data;
	word_t imm;
	logic  br_taken;

	// Decoded control bundle
	rv_ctrl_if ctrl ();

	rv_decoder u_decoder (
		.instr_i (instr_i),
		.ctrl_o  (ctrl)
	);

	// Register bank, also drives the writeback strobe
	rv_regfile u_regfile (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ctrl_i     (ctrl),
		.wr_data_i  (rd_data_o),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wr_en_o    (rd_wr_en_o)
	);

	rv_execute u_execute (
		.ctrl_i       (ctrl),
		.instr_i      (instr_i),
		.pc_i         (pc_o),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.imm_o        (imm),
		.alu_result_o (alu_result_o),
		.wb_data_o    (rd_data_o),
		.br_taken_o   (br_taken)
	);

	rv_pc u_pc (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ctrl_i     (ctrl),
		.imm_i      (imm),
		.br_taken_i (br_taken),
		.pc_o       (pc_o)
	);

	// Architectural checks on every retired instruction
	rv_props u_props (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ctrl_i     (ctrl),
		.pc_i       (pc_o),
		.imm_i      (imm),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.wb_data_i  (rd_data_o)
	);

	assign rd_addr_o = ctrl.rd;

endmodule

`default_nettype wire

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
	import rv_pkg::*;

	typedef enum int {OP_NONE, OP_ADDI, OP_ADD, OP_SUB, OP_BEQ, OP_JAL} tb_op_e;

	logic      clk;
	logic      rst_n_i;
	word_t     instr_i;
	word_t     pc_o;
	word_t     alu_result_o;
	logic      rd_wr_en_o;
	reg_addr_t rd_addr_o;
	word_t     rd_data_o;

	// Instruction memory plus what each slot means to the model
	word_t     prog [0:63];
	tb_op_e    ops  [0:63];
	reg_addr_t rds  [0:63];
	reg_addr_t rs1s [0:63];
	reg_addr_t rs2s [0:63];
	word_t     imms [0:63];

	// Architectural register model
	word_t     model [0:31];

	int errors;
	int checks;
	int seed;

	rv_core_top DUT (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.instr_i      (instr_i),
		.pc_o         (pc_o),
		.alu_result_o (alu_result_o),
		.rd_wr_en_o   (rd_wr_en_o),
		.rd_addr_o    (rd_addr_o),
		.rd_data_o    (rd_data_o)
	);

	always #4 clk = ~clk;

	// Fetch from the word that pc points at
	always @(posedge clk) begin
		#1;
		instr_i = prog[pc_o[7:2]];
	end

	function automatic word_t sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic word_t random_imm12(bit negative);
		logic [11:0] raw;
		raw = 12'($urandom);
		if (negative) begin
			raw[11] = 1'b1;
		end
		return sext12(raw);
	endfunction

	// Instruction encodings
	function automatic word_t r_type_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
	                                      reg_addr_t rd);
		return {f7, rs2, rs1, 3'b000, rd, OPCODE_R_TYPE};
	endfunction

	function automatic word_t addi_word(reg_addr_t rd, reg_addr_t rs1, word_t imm);
		return {imm[11:0], rs1, 3'b000, rd, OPCODE_I_TYPE};
	endfunction

	function automatic word_t beq_word(reg_addr_t rs1, reg_addr_t rs2, word_t imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPCODE_B_TYPE};
	endfunction

	function automatic word_t jal_word(reg_addr_t rd, word_t imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_J_TYPE};
	endfunction

	// custom-0 opcode, undecoded so it runs as a no-op
	function automatic void fill_program();
		for (int i = 0; i < 64; i++) begin
			prog[i] = {i[24:0], 7'h0B};
			ops[i]  = OP_NONE;
			rds[i]  = '0;
			rs1s[i] = '0;
			rs2s[i] = '0;
			imms[i] = '0;
		end
	endfunction

	function automatic void place_instr(int slot, tb_op_e op, reg_addr_t rd,
	                                    reg_addr_t rs1, reg_addr_t rs2, word_t imm);
		ops[slot]  = op;
		rds[slot]  = rd;
		rs1s[slot] = rs1;
		rs2s[slot] = rs2;
		imms[slot] = imm;
		case (op)
			OP_ADDI: prog[slot] = addi_word(rd, rs1, imm);
			OP_ADD:  prog[slot] = r_type_word(FUNCT7_ADD, rs2, rs1, rd);
			OP_SUB:  prog[slot] = r_type_word(FUNCT7_SUB, rs2, rs1, rd);
			OP_BEQ:  prog[slot] = beq_word(rs1, rs2, imm);
			OP_JAL:  prog[slot] = jal_word(rd, imm);
			default: begin
			end
		endcase
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Settled point of a cycle, after the fetch delay
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// Eight edges with rst_n_i low, pc and strobe held off
	task automatic restart_core();
		@(posedge clk);
		#1;
		rst_n_i = 1'b0;
		for (int i = 0; i < 7; i++) begin
			next_cycle();
			check_word("pc_o", pc_o, '0);
			check_flag("rd_wr_en_o", rd_wr_en_o, 1'b0);
		end
		@(posedge clk);
		#1;
		rst_n_i = 1'b1;
		#1;
		check_word("pc_o", pc_o, '0);
		for (int r = 0; r < 32; r++) begin
			model[r] = '0;
		end
	endtask

	// Check one instruction's outputs, retire it, check the new pc
	task automatic run_step();
		int    slot;
		word_t pc_now;
		word_t exp_pc;
		word_t value;
		bit    writes;
		slot   = int'(pc_o[7:2]);
		pc_now = pc_o;
		exp_pc = pc_now + 32'd4;
		value  = '0;
		writes = 1'b0;
		case (ops[slot])
			OP_ADDI: begin
				value  = model[rs1s[slot]] + imms[slot];
				writes = 1'b1;
			end
			OP_ADD, OP_SUB: begin
				value  = (ops[slot] == OP_ADD) ? model[rs1s[slot]] + model[rs2s[slot]]
				                               : model[rs1s[slot]] - model[rs2s[slot]];
				writes = 1'b1;
				check_word("alu_result_o", alu_result_o, value);
			end
			OP_BEQ: begin
				if (model[rs1s[slot]] == model[rs2s[slot]]) begin
					exp_pc = pc_now + imms[slot];
				end
			end
			OP_JAL: begin
				// Link is the old pc plus 4
				value  = pc_now + 32'd4;
				writes = 1'b1;
				exp_pc = pc_now + imms[slot];
			end
			default: begin
			end
		endcase
		// x0 as destination never raises the strobe
		check_flag("rd_wr_en_o", rd_wr_en_o, writes && rds[slot] != '0);
		if (writes) begin
			check_addr("rd_addr_o", rd_addr_o, rds[slot]);
		end
		if (writes && rds[slot] != '0) begin
			check_word("rd_data_o", rd_data_o, value);
			model[rds[slot]] = value;
		end
		next_cycle();
		check_word("pc_o", pc_o, exp_pc);
	endtask

	task automatic wait_for_pc(word_t target, int max_cycles);
		int n;
		n = 0;
		while (pc_o != target && n < max_cycles) begin
			run_step();
			n++;
		end
		if (pc_o != target) begin
			errors++;
			$display("timeout: pc never reached %h within %0d cycles", target, max_cycles);
		end
	endtask

	task automatic reset_test();
		fill_program();
		restart_core();
		wait_for_pc(32'd24, 8);
	endtask

	// x1..x8, each built from the one before
	task automatic addi_chain();
		fill_program();
		for (int k = 0; k < 8; k++) begin
			place_instr(k, OP_ADDI, reg_addr_t'(k + 1), reg_addr_t'(k), 5'd0,
			            random_imm12(k % 2 == 0));
		end
		restart_core();
		wait_for_pc(32'd32, 12);
	endtask

	task automatic add_sub_sequence();
		fill_program();
		for (int k = 0; k < 4; k++) begin
			place_instr(k, OP_ADDI, reg_addr_t'(k + 1), 5'd0, 5'd0, random_imm12(k % 2 == 1));
		end
		place_instr(4, OP_ADD, 5'd5, 5'd1, 5'd2, '0);
		place_instr(5, OP_SUB, 5'd6, 5'd3, 5'd4, '0);
		place_instr(6, OP_ADD, 5'd7, 5'd5, 5'd6, '0);
		place_instr(7, OP_SUB, 5'd8, 5'd6, 5'd5, '0);
		// Negation wraps through zero
		place_instr(8, OP_SUB, 5'd9, 5'd0, 5'd7, '0);
		place_instr(9, OP_ADD, 5'd10, 5'd9, 5'd9, '0);
		restart_core();
		wait_for_pc(32'd40, 14);
	endtask

	task automatic x0_discard();
		fill_program();
		place_instr(0, OP_ADDI, 5'd1, 5'd0, 5'd0, random_imm12(1'b1));
		place_instr(1, OP_ADDI, 5'd0, 5'd1, 5'd0, sext12(12'h005));
		place_instr(2, OP_ADD, 5'd0, 5'd1, 5'd1, '0);
		// x0 as an operand passes the other side through
		place_instr(3, OP_ADD, 5'd2, 5'd0, 5'd1, '0);
		place_instr(4, OP_SUB, 5'd3, 5'd1, 5'd0, '0);
		restart_core();
		wait_for_pc(32'd20, 8);
	endtask

	// Path 0, 1, 2, 8, 9, 4, 14 by slot
	task automatic beq_branches();
		fill_program();
		place_instr(0, OP_ADDI, 5'd1, 5'd0, 5'd0, sext12(12'h007));
		place_instr(1, OP_ADDI, 5'd2, 5'd0, 5'd0, sext12(12'h009));
		place_instr(2, OP_BEQ, 5'd0, 5'd1, 5'd1, 32'd24);
		place_instr(8, OP_BEQ, 5'd0, 5'd1, 5'd2, 32'd32);
		place_instr(9, OP_BEQ, 5'd0, 5'd0, 5'd0, word_t'(-20));
		place_instr(4, OP_BEQ, 5'd0, 5'd2, 5'd2, 32'd40);
		restart_core();
		wait_for_pc(32'd56, 10);
	endtask

	// Path 0, 3, 8, 2, 12 by slot, then the links are summed
	task automatic jal_jumps();
		fill_program();
		place_instr(0, OP_JAL, 5'd1, 5'd0, 5'd0, 32'd12);
		place_instr(3, OP_JAL, 5'd0, 5'd0, 5'd0, 32'd20);
		place_instr(8, OP_JAL, 5'd5, 5'd0, 5'd0, word_t'(-24));
		place_instr(2, OP_JAL, 5'd7, 5'd0, 5'd0, 32'd40);
		place_instr(12, OP_ADD, 5'd6, 5'd1, 5'd5, '0);
		restart_core();
		wait_for_pc(32'd52, 10);
	endtask

	initial begin
		seed = 32'h6c82_d1bd;
		void'($urandom(seed));
		errors  = 0;
		checks  = 0;
		clk     = 1'b0;
		rst_n_i = 1'b0;
		instr_i = '0;
		fill_program();

		reset_test();
		addi_chain();
		add_sub_sequence();
		x0_discard();
		beq_branches();
		jal_jumps();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rv_core_top.f
hdl/rv_pkg.sv
hdl/rv_ctrl_if.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_pc.sv
hdl/rv_props.sv
hdl/rv_core_top.sv
tb/rv_core_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -sv --top-module rv_core_tb -f rv_core_top.f -Mdir obj_dir
	./obj_dir/Vrv_core_tb > sim.log 2>&1; cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
